//--- list.f
+incdir+verification
verilog/xgmii_rx_pkg.sv
verilog/xgmii_lane_pipe.sv
verilog/xgmii_start_detect.sv
verilog/xgmii_rx_fsm.sv
verilog/xgmii_axis_rx.sv
verification/tb_xgmii_axis_rx.sv

//--- Makefile
# Verilator build and run of the XGMII receive bridge testbench

VERILATOR ?= verilator
TOP       ?= tb_xgmii_axis_rx
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/100ps
SOURCES   := $(wildcard verilog/*.sv verification/*.sv verification/*.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- verification/xgmii_frame_ref.svh
// frame encoder and beat reference model, included inside the testbench module
`ifndef XGMII_FRAME_REF_SVH
`define XGMII_FRAME_REF_SVH

typedef logic [7:0] byte_q_t[$];

// all lanes carry the idle control character
function automatic xgmii_rx_pkg::xgmii_word_t idle_word();
    xgmii_rx_pkg::xgmii_word_t w;
    w.data = {xgmii_rx_pkg::lanes{xgmii_rx_pkg::xgmii_idle}};
    w.ctrl = '1;
    return w;
endfunction

// words from the start word up to and including the word that holds END
function automatic int frame_words(input int len, input int start_lane);
    return (start_lane + len + 8) / 8 + 1;
endfunction

// one word of a frame, counted from the start word
// from the start lane on the byte stream is start, seven preamble bytes,
// the payload and END, and every other lane stays idle
// ctrl_pos marks one payload byte that goes out as a control character
function automatic xgmii_rx_pkg::xgmii_word_t encode_word(input byte_q_t payload,
        input int start_lane, input int ctrl_pos, input int index);
    xgmii_rx_pkg::xgmii_word_t w;
    int off;
    w = idle_word();
    for (int lane = 0; lane < xgmii_rx_pkg::lanes; lane++) begin
        off = index * 8 + lane - start_lane;
        if (off == 0) begin
            w.data[lane*8 +: 8] = xgmii_rx_pkg::xgmii_start;
        end else if (off > 0 && off < 8) begin
            w.data[lane*8 +: 8] = xgmii_rx_pkg::eth_preamble[off*8 +: 8];
            w.ctrl[lane] = 1'b0;
        end else if (off >= 8 && off - 8 < payload.size()) begin
            w.data[lane*8 +: 8] = payload[off - 8];
            w.ctrl[lane] = (off - 8 == ctrl_pos);
        end else if (off - 8 == payload.size()) begin
            w.data[lane*8 +: 8] = xgmii_rx_pkg::xgmii_end;
        end
    end
    return w;
endfunction

function automatic int beat_count(input int len);
    return (len + 7) / 8;
endfunction

// what the receiver should deliver, the payload cut into 8 byte beats
// the final beat keeps only the bytes that are left and carries last
function automatic xgmii_rx_pkg::axis_beat_t expected_beat(input byte_q_t payload,
        input int index);
    xgmii_rx_pkg::axis_beat_t b;
    int pos;
    b = '0;
    b.valid = 1'b1;
    for (int lane = 0; lane < xgmii_rx_pkg::lanes; lane++) begin
        pos = index * 8 + lane;
        if (pos < payload.size()) begin
            b.data[lane*8 +: 8] = payload[pos];
            b.keep[lane] = 1'b1;
        end
    end
    b.last = (index * 8 + 8 >= payload.size());
    return b;
endfunction

`endif

//--- verification/tb_xgmii_axis_rx.sv
// testbench for the XGMII receive bridge, built and run through the Makefile with Verilator
`timescale 1ns/100ps

module tb_xgmii_axis_rx;

    `include "xgmii_frame_ref.svh"

    logic                      clk;
    logic                      rst;
    xgmii_rx_pkg::xgmii_word_t rx;
    logic                      ready;
    xgmii_rx_pkg::axis_beat_t  beat;
    xgmii_rx_pkg::rx_errors_t  errors;

    // expected beats, the error pulses that come with each beat, and pulses without a beat
    xgmii_rx_pkg::axis_beat_t  beat_q[$];
    xgmii_rx_pkg::rx_errors_t  beat_err_q[$];
    xgmii_rx_pkg::rx_errors_t  pulse_q[$];
    byte_q_t                   payload;
    int                        seed;

    xgmii_axis_rx dut0 (
        .clk    (clk),
        .rst    (rst),
        .rx     (rx),
        .ready  (ready),
        .beat   (beat),
        .errors (errors)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic report_mismatch(input string what);
        abort_run($sformatf("error at %0t ns: %s", $time, what));
    endtask

    // bytes outside the keep mask carry no meaning and are skipped
    task automatic check_beat(input xgmii_rx_pkg::axis_beat_t got,
                              input xgmii_rx_pkg::axis_beat_t exp);
        if (got.keep !== exp.keep || got.last !== exp.last) begin
            report_mismatch($sformatf("beat keep %h last %b, expected keep %h last %b",
                                      got.keep, got.last, exp.keep, exp.last));
        end
        for (int i = 0; i < xgmii_rx_pkg::lanes; i++) begin
            if (exp.keep[i] && got.data[i*8 +: 8] !== exp.data[i*8 +: 8]) begin
                report_mismatch($sformatf("beat lane %0d data %h, expected %h",
                                          i, got.data[i*8 +: 8], exp.data[i*8 +: 8]));
            end
        end
    endtask

    task automatic check_errors(input xgmii_rx_pkg::rx_errors_t got,
                                input xgmii_rx_pkg::rx_errors_t exp);
        if (got !== exp) begin
            report_mismatch($sformatf("errors ready %b preamble %b xgmii %b, expected %b %b %b",
                                      got.ready, got.preamble, got.xgmii,
                                      exp.ready, exp.preamble, exp.xgmii));
        end
    endtask

    // outputs change on the rising edge, so they are compared on the falling edge
    initial begin
        xgmii_rx_pkg::axis_beat_t exp_beat;
        xgmii_rx_pkg::rx_errors_t exp_err;
        forever begin
            @(negedge clk);
            if (!rst && beat.valid) begin
                if (beat_q.size() == 0) begin
                    abort_run("a beat came out of the DUT while none was expected");
                end else begin
                    exp_beat = beat_q.pop_front();
                    exp_err = beat_err_q.pop_front();
                    check_beat(beat, exp_beat);
                    check_errors(errors, exp_err);
                end
            end else if (!rst && errors != '0) begin
                // a pulse with nothing queued is compared against no error at all
                exp_err = '0;
                if (pulse_q.size() != 0) begin
                    exp_err = pulse_q.pop_front();
                end
                check_errors(errors, exp_err);
            end
        end
    end

    task automatic drive_word(input xgmii_rx_pkg::xgmii_word_t w);
        @(posedge clk);
        rx <= w;
    endtask

    task automatic random_payload(input int n);
        int r;
        payload = {};
        for (int i = 0; i < n; i++) begin
            r = $random(seed);
            payload.push_back(r[7:0]);
        end
    endtask

    // the bus idles until every queued beat and pulse has come out
    task automatic wait_drain(input int limit);
        int cycles;
        cycles = 0;
        while (beat_q.size() != 0 || pulse_q.size() != 0) begin
            if (cycles == limit) begin
                abort_run("timeout while waiting for expected beats or error pulses");
            end
            drive_word(idle_word());
            cycles++;
        end
    endtask

    // queue what the receiver should produce, then put two idle words and the frame on the bus
    task automatic send_frame(input int start_lane, input int ctrl_pos,
                              input bit bad_preamble, input bit ready_low);
        xgmii_rx_pkg::xgmii_word_t w;
        xgmii_rx_pkg::rx_errors_t  e;
        xgmii_rx_pkg::axis_beat_t  b;
        int                        n_words;
        n_words = frame_words(payload.size(), start_lane);
        if (bad_preamble) begin
            // aligned start only, the FSM stays idle and each later word breaks the idle rule
            e = '0;
            e.preamble = 1'b1;
            pulse_q.push_back(e);
            e = '0;
            e.xgmii = 1'b1;
            for (int i = 1; i < n_words; i++) begin
                pulse_q.push_back(e);
            end
        end else begin
            for (int k = 0; k < beat_count(payload.size()); k++) begin
                if (ctrl_pos < 0 || k <= ctrl_pos / 8) begin
                    e = '0;
                    e.ready = ready_low;
                    b = expected_beat(payload, k);
                    if (ctrl_pos >= 0 && k == ctrl_pos / 8) begin
                        // the word with the control character closes the frame early
                        e.xgmii = 1'b1;
                        b.last = 1'b1;
                    end
                    beat_q.push_back(b);
                    beat_err_q.push_back(e);
                end
            end
            if (ctrl_pos >= 0) begin
                // aligned start only, the rest of the frame reaches an idle FSM
                e = '0;
                e.xgmii = 1'b1;
                for (int i = ctrl_pos / 8 + 2; i < n_words; i++) begin
                    pulse_q.push_back(e);
                end
            end
        end
        ready <= !ready_low;
        drive_word(idle_word());
        drive_word(idle_word());
        for (int i = 0; i < n_words; i++) begin
            w = encode_word(payload, start_lane, ctrl_pos, i);
            if (bad_preamble && i == 0) begin
                // third preamble byte after the start character
                w.data[start_lane*8 + 24 +: 8] = 8'h54;
            end
            drive_word(w);
        end
        wait_drain(64);
        ready <= 1'b1;
    endtask

    initial begin
        int r;
        seed = 32'h1819d0e4;
        rst = 1'b1;
        ready = 1'b1;
        rx = idle_word();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        // random lengths, every payload once aligned and once starting on lane 4
        for (int f = 0; f < 16; f++) begin
            r = $random(seed);
            random_payload((r & 63) + 1);
            send_frame(0, -1, 1'b0, 1'b0);
            send_frame(4, -1, 1'b0, 1'b0);
        end
        // whole words only, so END opens the word after the payload
        for (int n = 8; n <= 64; n += 8) begin
            random_payload(n);
            send_frame(0, -1, 1'b0, 1'b0);
            send_frame(4, -1, 1'b0, 1'b0);
        end
        // broken preamble drops the frame, the same payload then goes through clean
        random_payload(20);
        send_frame(0, -1, 1'b1, 1'b0);
        send_frame(0, -1, 1'b0, 1'b0);
        // XGMII error character in the middle of the payload cuts the frame short
        payload[10] = 8'hFE;
        send_frame(0, 10, 1'b0, 1'b0);
        random_payload(33);
        send_frame(0, -1, 1'b0, 1'b0);
        // ready low over whole frames still delivers every beat
        random_payload(40);
        send_frame(0, -1, 1'b0, 1'b1);
        send_frame(4, -1, 1'b0, 1'b1);
        // a few quiet cycles so a stray late pulse is still seen
        repeat (4) drive_word(idle_word());
        $display("Test OK");
        $finish;
    end

endmodule

//--- verilog/xgmii_axis_rx.sv
// top level of the 64-bit XGMII receive to AXI4-Stream bridge, wires the pipeline blocks
`timescale 1ns/100ps

module xgmii_axis_rx (
    input  logic                      clk,
    input  logic                      rst,
    input  xgmii_rx_pkg::xgmii_word_t rx,
    input  logic                      ready,
    output xgmii_rx_pkg::axis_beat_t  beat,
    output xgmii_rx_pkg::rx_errors_t  errors
);

    xgmii_rx_pkg::xgmii_word_t word_d;
    logic [7:0]                keep_d;
    xgmii_rx_pkg::xgmii_half_t prev_half;
    logic                      next_end;
    xgmii_rx_pkg::start_kind_e start_kind;
    logic                      idle_error;
    logic                      shifted_preamble_ok;
    logic                      tolerate_end;

    // one cycle of delay plus mask encoding and the half-word buffer
    xgmii_lane_pipe lane_pipe0 (
        .clk       (clk),
        .rst       (rst),
        .rx        (rx),
        .word_d    (word_d),
        .keep_d    (keep_d),
        .prev_half (prev_half),
        .next_end  (next_end)
    );

    // purely combinational, feeds the FSM in the same cycle
    xgmii_start_detect start_detect0 (
        .word_d              (word_d),
        .prev_half           (prev_half),
        .tolerate_end        (tolerate_end),
        .start_kind          (start_kind),
        .idle_error          (idle_error),
        .shifted_preamble_ok (shifted_preamble_ok)
    );

    // tolerate_end loops back from the FSM into the idle check
    xgmii_rx_fsm rx_fsm0 (
        .clk                 (clk),
        .rst                 (rst),
        .word_d              (word_d),
        .keep_d              (keep_d),
        .prev_half           (prev_half),
        .next_end            (next_end),
        .start_kind          (start_kind),
        .idle_error          (idle_error),
        .shifted_preamble_ok (shifted_preamble_ok),
        .ready               (ready),
        .tolerate_end        (tolerate_end),
        .beat                (beat),
        .errors              (errors)
    );

endmodule

//--- verilog/xgmii_rx_fsm.sv
// receive FSM that turns classified XGMII words into output beats and error pulses
`timescale 1ns/100ps

module xgmii_rx_fsm (
    input  logic                      clk,
    input  logic                      rst,
    input  xgmii_rx_pkg::xgmii_word_t word_d,
    input  logic [7:0]                keep_d,
    input  xgmii_rx_pkg::xgmii_half_t prev_half,
    input  logic                      next_end,
    input  xgmii_rx_pkg::start_kind_e start_kind,
    input  logic                      idle_error,
    input  logic                      shifted_preamble_ok,
    input  logic                      ready,
    output logic                      tolerate_end,
    output xgmii_rx_pkg::axis_beat_t  beat,
    output xgmii_rx_pkg::rx_errors_t  errors
);

    xgmii_rx_pkg::rx_state_e  state;
    xgmii_rx_pkg::rx_state_e  state_next;
    xgmii_rx_pkg::axis_beat_t beat_next;
    xgmii_rx_pkg::rx_errors_t errors_next;
    logic                     tolerate_next;

    always_comb begin
        state_next = state;
        beat_next.valid = 1'b0;
        beat_next.data = word_d.data;
        beat_next.last = 1'b0;
        beat_next.keep = 8'hFF;
        errors_next = '0;
        tolerate_next = 1'b0;

        case (state)
            xgmii_rx_pkg::rx_idle: begin
                errors_next.xgmii = idle_error;
                case (start_kind)
                    xgmii_rx_pkg::start_aligned: state_next = xgmii_rx_pkg::rx_unshifted;
                    xgmii_rx_pkg::start_aligned_bad_preamble: errors_next.preamble = 1'b1;
                    xgmii_rx_pkg::start_shifted: state_next = xgmii_rx_pkg::rx_shifted_preamble;
                    default: state_next = xgmii_rx_pkg::rx_idle;
                endcase
            end

            xgmii_rx_pkg::rx_shifted_preamble: begin
                // nothing to send yet, the second half of the preamble is in word_d
                if (shifted_preamble_ok) begin
                    state_next = xgmii_rx_pkg::rx_shifted;
                end else begin
                    state_next = xgmii_rx_pkg::rx_idle;
                    errors_next.preamble = 1'b1;
                end
            end

            xgmii_rx_pkg::rx_unshifted: begin
                if (keep_d == 8'h00) begin
                    // END right after the preamble, an empty frame has no valid
                    // preamble either so it is reported as such
                    state_next = xgmii_rx_pkg::rx_idle;
                    errors_next.preamble = 1'b1;
                end else begin
                    beat_next.valid = 1'b1;
                    errors_next.ready = !ready;
                    if (keep_d != 8'hFF) begin
                        beat_next.last = 1'b1;
                        beat_next.keep = keep_d;
                        state_next = xgmii_rx_pkg::rx_idle;
                    end else if (next_end) begin
                        // the next word only carries END on lane 0, finish now
                        // and let the idle check accept that character
                        beat_next.last = 1'b1;
                        tolerate_next = 1'b1;
                        state_next = xgmii_rx_pkg::rx_idle;
                    end
                    // a control character inside the kept lanes breaks the frame
                    if ((word_d.ctrl & keep_d) != 8'h00) begin
                        beat_next.last = 1'b1;
                        errors_next.xgmii = 1'b1;
                        state_next = xgmii_rx_pkg::rx_idle;
                    end
                end
            end

            xgmii_rx_pkg::rx_shifted: begin
                beat_next.valid = 1'b1;
                beat_next.data = {word_d.data[31:0], prev_half.data};
                errors_next.ready = !ready;
                // the two halves come from masks of different words, so the
                // end is searched for in order instead of joining the masks
                if (prev_half.keep != 4'hF) begin
                    beat_next.last = 1'b1;
                    beat_next.keep = {4'h0, prev_half.keep};
                    state_next = xgmii_rx_pkg::rx_idle;
                end else if (keep_d[3:0] != 4'hF) begin
                    beat_next.last = 1'b1;
                    beat_next.keep = {keep_d[3:0], 4'hF};
                    state_next = xgmii_rx_pkg::rx_idle;
                end else if (word_d.ctrl[4] &&
                             (word_d.data[39:32] == xgmii_rx_pkg::xgmii_end)) begin
                    // END opens the half that would start the next beat
                    // idle only looks at later words, so no tolerance is needed
                    beat_next.last = 1'b1;
                    state_next = xgmii_rx_pkg::rx_idle;
                end
                // lower half is only checked when the frame did not end in prev_half
                if (((prev_half.ctrl & prev_half.keep) != 4'h0) ||
                    ((prev_half.keep == 4'hF) && ((word_d.ctrl[3:0] & keep_d[3:0]) != 4'h0))) begin
                    beat_next.last = 1'b1;
                    errors_next.xgmii = 1'b1;
                    state_next = xgmii_rx_pkg::rx_idle;
                end
            end

            default: state_next = xgmii_rx_pkg::rx_idle;
        endcase
    end

    // beat payload is qualified by valid and needs no reset
    always_ff @(posedge clk) begin
        beat.data <= beat_next.data;
        beat.last <= beat_next.last;
        beat.keep <= beat_next.keep;
        if (rst) begin
            state <= xgmii_rx_pkg::rx_idle;
            tolerate_end <= 1'b0;
            beat.valid <= 1'b0;
            errors <= '0;
        end else begin
            state <= state_next;
            tolerate_end <= tolerate_next;
            beat.valid <= beat_next.valid;
            errors <= errors_next;
        end
    end

endmodule

//--- verilog/xgmii_start_detect.sv
// combinational classifier of the delayed word for frame start, preamble and idle checks
`timescale 1ns/100ps

module xgmii_start_detect (
    input  xgmii_rx_pkg::xgmii_word_t   word_d,
    input  xgmii_rx_pkg::xgmii_half_t   prev_half,
    input  logic                        tolerate_end,
    output xgmii_rx_pkg::start_kind_e   start_kind,
    output logic                        idle_error,
    output logic                        shifted_preamble_ok
);

    logic start_lane0;
    logic start_lane4;
    logic aligned_preamble_ok;
    logic lower_all_idle;
    logic upper_all_idle;
    logic lane0_ok;

    // start character on the first lane of either half
    assign start_lane0 = word_d.ctrl[0] && (word_d.data[7:0] == xgmii_rx_pkg::xgmii_start);
    assign start_lane4 = word_d.ctrl[4] && (word_d.data[39:32] == xgmii_rx_pkg::xgmii_start);

    // an aligned start carries the whole preamble in lanes 1 to 7, all as data
    assign aligned_preamble_ok = (word_d.ctrl[7:1] == 7'b0) &&
                                 (word_d.data[63:8] == xgmii_rx_pkg::eth_preamble[63:8]);

    // a lane 4 start needs a clean lower half, the minimum IFG rules out
    // the tail of a previous frame there
    assign lower_all_idle = (word_d.ctrl[3:0] == 4'hF) &&
        (word_d.data[31:0] == {xgmii_rx_pkg::half_lanes{xgmii_rx_pkg::xgmii_idle}});

    // without a start every lane must be idle, lane 0 is judged on its own
    assign upper_all_idle = (word_d.ctrl == 8'hFF) &&
        (word_d.data[63:8] == {(xgmii_rx_pkg::lanes - 1){xgmii_rx_pkg::xgmii_idle}});

    // after a lookahead end the END character itself still sits on lane 0
    assign lane0_ok = (word_d.data[7:0] == xgmii_rx_pkg::xgmii_idle) ||
                      (tolerate_end && (word_d.data[7:0] == xgmii_rx_pkg::xgmii_end));

    always_comb begin
        start_kind = xgmii_rx_pkg::start_none;
        idle_error = 1'b0;
        if (start_lane0) begin
            // lane 0 wins, a second start on lane 4 would be a preamble fault anyway
            if (aligned_preamble_ok) begin
                start_kind = xgmii_rx_pkg::start_aligned;
            end else begin
                start_kind = xgmii_rx_pkg::start_aligned_bad_preamble;
            end
        end else if (start_lane4) begin
            start_kind = xgmii_rx_pkg::start_shifted;
            idle_error = !lower_all_idle;
        end else begin
            idle_error = !(upper_all_idle && lane0_ok);
        end
    end

    // shifted preamble is split over two words, three bytes after the start
    // in the buffered half and the delimiter end in the lower half of word_d
    assign shifted_preamble_ok =
        ({word_d.ctrl[3:0], prev_half.ctrl[3:1]} == 7'b0) &&
        ({word_d.data[31:0], prev_half.data[31:8]} == xgmii_rx_pkg::eth_preamble[63:8]);

endmodule

//--- verilog/xgmii_lane_pipe.sv
// delays the XGMII word by one cycle, encodes its tkeep mask and keeps the previous upper half
`timescale 1ns/100ps

module xgmii_lane_pipe (
    input  logic                      clk,
    input  logic                      rst,
    input  xgmii_rx_pkg::xgmii_word_t rx,
    output xgmii_rx_pkg::xgmii_word_t word_d,
    output logic [7:0]                keep_d,
    output xgmii_rx_pkg::xgmii_half_t prev_half,
    output logic                      next_end
);

    logic [7:0] keep_live;

    // scan the live word from lane 0 upwards, the mask stays set until the
    // first END character and is clear from there on
    // working on the undelayed word lets the mask share the pipeline register
    always_comb begin
        logic run;
        run = 1'b1;
        for (int i = 0; i < xgmii_rx_pkg::lanes; i++) begin
            if (rx.ctrl[i] && (rx.data[i*8 +: 8] == xgmii_rx_pkg::xgmii_end)) begin
                run = 1'b0;
            end
            keep_live[i] = run;
        end
    end

    // word and mask move together so the FSM always sees a matching pair
    // both come out of reset as an idle word, which the idle checker accepts
    always_ff @(posedge clk) begin
        if (rst) begin
            word_d.data <= {xgmii_rx_pkg::lanes{xgmii_rx_pkg::xgmii_idle}};
            word_d.ctrl <= '1;
            keep_d <= '0;
        end else begin
            word_d <= rx;
            keep_d <= keep_live;
        end
    end

    // upper half of the delayed word, one more cycle late
    // a shifted beat is this half joined with the lower half of word_d
    always_ff @(posedge clk) begin
        if (rst) begin
            prev_half.data <= {xgmii_rx_pkg::half_lanes{xgmii_rx_pkg::xgmii_idle}};
            prev_half.ctrl <= '1;
            prev_half.keep <= '0;
        end else begin
            prev_half.data <= word_d.data[63:32];
            prev_half.ctrl <= word_d.ctrl[7:4];
            prev_half.keep <= keep_d[7:4];
        end
    end

    // lookahead for the FSM, the word after word_d opens with END
    // so the current aligned beat has to be the last one
    assign next_end = rx.ctrl[0] && (rx.data[7:0] == xgmii_rx_pkg::xgmii_end);

endmodule

//--- verilog/xgmii_rx_pkg.sv
// shared XGMII and Ethernet constants, bus structs and state enums for the receive bridge
package xgmii_rx_pkg;

    // XGMII control character codes, valid only where the lane's control bit is set
    localparam logic [7:0] xgmii_idle = 8'h07;
    localparam logic [7:0] xgmii_start = 8'hFB;
    localparam logic [7:0] xgmii_end = 8'hFD;

    // preamble and start of frame delimiter as seen on the bus, lane 0 in the low byte
    // the low byte is replaced by the start character on the wire
    localparam logic [63:0] eth_preamble = 64'hD555555555555555;

    // bus geometry of the 64-bit XGMII variant
    localparam int lanes = 8;
    localparam int half_lanes = lanes / 2;
    localparam int data_w = lanes * 8;

    // one XGMII bus word, lane n sits in data[8n+7:8n] and ctrl[n]
    typedef struct packed {
        logic [data_w-1:0] data;
        logic [lanes-1:0]  ctrl;
    } xgmii_word_t;

    // upper half of a bus word, kept for one cycle so that a frame starting
    // on lane 4 can be rebuilt into full 8 byte beats
    typedef struct packed {
        logic [half_lanes*8-1:0] data;
        logic [half_lanes-1:0]   ctrl;
        logic [half_lanes-1:0]   keep;
    } xgmii_half_t;

    // one output beat in AXI4-Stream terms, valid is a single cycle strobe
    typedef struct packed {
        logic              valid;
        logic [data_w-1:0] data;
        logic              last;
        logic [lanes-1:0]  keep;
    } axis_beat_t;

    // each field pulses for exactly one cycle
    typedef struct packed {
        logic ready;
        logic preamble;
        logic xgmii;
    } rx_errors_t;

    // what an idle-state word looks like to the start detector
    typedef enum logic [1:0] {
        start_none,
        start_aligned,
        start_aligned_bad_preamble,
        start_shifted
    } start_kind_e;

    // receive FSM states
    typedef enum logic [1:0] {
        rx_idle,
        rx_shifted_preamble,
        rx_unshifted,
        rx_shifted
    } rx_state_e;

endpackage
